// File: Bender.yml
package:
  name: game_display

sources:
  - game_pkg.sv
  - raster_timing.sv
  - map_memory.sv
  - map_axil_regs.sv
  - drawcon.sv
  - game_display_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - game_display_properties.sv
      - tb_game_display.sv

// File: drawcon.sv
`timescale 1ns/1ps

module drawcon #(
  parameter int SCREEN_W = 1280,
  parameter int SCREEN_H = 800,
  parameter int BRD_H    = 32,  // left and right border width
  parameter int BRD_TOP  = 96,
  parameter int BRD_BOT  = 0,
  parameter int BLK_W    = 64,  // power of 2
  parameter int BLK_H    = 64,  // power of 2
  parameter int NUM_COL  = 19,
  parameter int NUM_ROW  = 11,
  localparam int ADDR_WIDTH = $clog2(NUM_COL * NUM_ROW)
) (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic [10:0]             i_draw_x,
  input  logic [9:0]              i_draw_y,
  input  game_pkg::sync_t         i_sync,
  input  logic [10:0]             i_player_x,
  input  logic [9:0]              i_player_y,
  input  game_pkg::tile_state_e   i_tile_state, // one cycle after o_map_addr
  output logic [ADDR_WIDTH-1:0]   o_map_addr,
  output game_pkg::rgb_t          o_rgb,
  output game_pkg::sync_t         o_sync
);

  localparam int BLK_W_LOG2 = $clog2(BLK_W);
  localparam int BLK_H_LOG2 = $clog2(BLK_H);

  logic                  out_of_map;
  logic                  is_player;
  logic [10:0]           map_x;
  logic [9:0]            map_y;
  logic [ADDR_WIDTH-1:0] col, row;
  logic [11:0]           player_x_end;
  logic [10:0]           player_y_end;
  logic                  out_of_map_q;
  logic                  is_player_q;
  game_pkg::sync_t       sync_q;
  game_pkg::rgb_t        rgb_next;

  // stage 0, classify the coordinate
  always_comb begin
    out_of_map = (i_draw_x < 11'(BRD_H)) || (i_draw_x >= 11'(SCREEN_W - BRD_H)) ||
                 (i_draw_y < 10'(BRD_TOP)) || (i_draw_y >= 10'(SCREEN_H - BRD_BOT));
  end

  // offset by the border, then divide by block size
  assign map_x = i_draw_x - 11'(BRD_H);
  assign map_y = i_draw_y - 10'(BRD_TOP);

  always_comb begin
    col        = ADDR_WIDTH'(map_x >> BLK_W_LOG2);
    row        = ADDR_WIDTH'(map_y >> BLK_H_LOG2);
    o_map_addr = out_of_map ? '0 : ADDR_WIDTH'(row * NUM_COL + col); // keep it in range
  end

  // one bit wider so the far edge cannot wrap
  assign player_x_end = {1'b0, i_player_x} + 12'(BLK_W);
  assign player_y_end = {1'b0, i_player_y} + 11'(BLK_H);

  assign is_player = (i_draw_x >= i_player_x) && ({1'b0, i_draw_x} < player_x_end) &&
                     (i_draw_y >= i_player_y) && ({1'b0, i_draw_y} < player_y_end);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_of_map_q <= 1'b1;
      is_player_q  <= 1'b0;
      sync_q       <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0}; // idle syncs
    end else begin
      out_of_map_q <= out_of_map;
      is_player_q  <= is_player;
      sync_q       <= i_sync;
    end
  end

  // stage 1, priority is border, player, tile
  always_comb begin
    rgb_next = game_pkg::COL_BG;
    if (out_of_map_q) begin
      rgb_next = game_pkg::COL_BORDER;
    end else if (is_player_q) begin
      rgb_next = game_pkg::COL_PLAYER;
    end else begin
      unique case (i_tile_state)
        game_pkg::no_blk:          rgb_next = game_pkg::COL_BG;
        game_pkg::perm_blk:        rgb_next = game_pkg::COL_PERM;
        game_pkg::destroyable_blk: rgb_next = game_pkg::COL_DESTR;
        game_pkg::bomb:            rgb_next = game_pkg::COL_BOMB;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rgb  <= '0;
      o_sync <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
    end else begin
      o_rgb  <= rgb_next;
      o_sync <= sync_q; // two cycles behind the counters
    end
  end

endmodule

// File: game_display_properties.sv
`timescale 1ns/1ps

module game_display_properties (
  input logic               i_clk,
  input logic               i_arst_n,
  input logic               i_awvalid,
  input logic               o_awready,
  input logic               o_bvalid,
  input logic               i_bready,
  input game_pkg::axil_b_t  o_b,
  input logic               o_rvalid,
  input logic               i_rready,
  input game_pkg::axil_r_t  o_r,
  input logic               o_hsync,
  input logic               o_vsync,
  input logic               o_de
);

  int assert_fails = 0; // failed assertion count

  // B stays up with a steady payload until taken
  a_b_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_b))
    else begin assert_fails++; $error("write response dropped or changed before bready"); end

  // same for R
  a_r_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_r))
    else begin assert_fails++; $error("read response dropped or changed before rready"); end

  // an accepted write raises B, which holds off the next one
  a_no_aw_in_b: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_awvalid && o_awready |=> o_bvalid && !o_awready)
    else begin assert_fails++; $error("write accepted without a response blocking the next"); end

  // blanking covers both sync pulses
  a_de_in_sync: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (!o_hsync || !o_vsync) |-> !o_de)
    else begin assert_fails++; $error("data enable high inside a sync pulse"); end

endmodule

bind game_display_top game_display_properties game_display_properties_i (.*);

// File: game_display_top.sv
`timescale 1ns/1ps

module game_display_top #(
  parameter int SCREEN_W = 1280,
  parameter int SCREEN_H = 800,
  parameter int BRD_H    = 32,
  parameter int BRD_TOP  = 96,
  parameter int BRD_BOT  = 0,
  parameter int BLK_W    = 64,
  parameter int BLK_H    = 64,
  parameter int NUM_COL  = 19,  // 32 + 19*64 + 32 = 1280
  parameter int NUM_ROW  = 11,  // 96 + 11*64 = 800
  parameter int H_FP     = 48,
  parameter int H_SYNC   = 32,
  parameter int H_BP     = 80,
  parameter int V_FP     = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BP     = 14
) (
  input  logic                i_clk,     // pixel clock
  input  logic                i_arst_n,
  input  logic                i_awvalid,
  output logic                o_awready,
  input  game_pkg::axil_aw_t  i_aw,
  input  logic                i_wvalid,
  output logic                o_wready,
  input  game_pkg::axil_w_t   i_w,
  output logic                o_bvalid,
  input  logic                i_bready,
  output game_pkg::axil_b_t   o_b,
  input  logic                i_arvalid,
  output logic                o_arready,
  input  game_pkg::axil_ar_t  i_ar,
  output logic                o_rvalid,
  input  logic                i_rready,
  output game_pkg::axil_r_t   o_r,
  output game_pkg::rgb_t      o_rgb,
  output logic                o_hsync,
  output logic                o_vsync,
  output logic                o_de
);

  localparam int ADDR_WIDTH = $clog2(NUM_COL * NUM_ROW);

  logic                  mem_we, mem_re;
  logic [ADDR_WIDTH-1:0] mem_addr;
  game_pkg::tile_state_e mem_wstate, mem_rstate;
  logic [ADDR_WIDTH-1:0] disp_addr;
  game_pkg::tile_state_e disp_state;
  logic [10:0]           player_x, draw_x;
  logic [9:0]            player_y, draw_y;
  game_pkg::sync_t       scan_sync, pix_sync;

  map_axil_regs #(.NUM_COL(NUM_COL), .NUM_ROW(NUM_ROW)) map_axil_regs_i (
    .i_clk, .i_arst_n,
    .i_awvalid, .o_awready, .i_aw,
    .i_wvalid, .o_wready, .i_w,
    .o_bvalid, .i_bready, .o_b,
    .i_arvalid, .o_arready, .i_ar,
    .o_rvalid, .i_rready, .o_r,
    .o_mem_we(mem_we), .o_mem_re(mem_re), .o_mem_addr(mem_addr),
    .o_mem_wstate(mem_wstate), .i_mem_rstate(mem_rstate),
    .o_player_x(player_x), .o_player_y(player_y)
  );

  map_memory #(.NUM_COL(NUM_COL), .NUM_ROW(NUM_ROW)) map_memory_i (
    .i_clk, .i_arst_n,
    .i_a_we(mem_we), .i_a_re(mem_re), .i_a_addr(mem_addr),
    .i_a_wstate(mem_wstate), .o_a_rstate(mem_rstate),
    .i_b_addr(disp_addr), .o_b_state(disp_state)
  );

  raster_timing #(
    .SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H),
    .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) raster_timing_i (
    .i_clk, .i_arst_n,
    .o_draw_x(draw_x), .o_draw_y(draw_y), .o_sync(scan_sync)
  );

  drawcon #(
    .SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H),
    .BRD_H(BRD_H), .BRD_TOP(BRD_TOP), .BRD_BOT(BRD_BOT),
    .BLK_W(BLK_W), .BLK_H(BLK_H), .NUM_COL(NUM_COL), .NUM_ROW(NUM_ROW)
  ) drawcon_i (
    .i_clk, .i_arst_n,
    .i_draw_x(draw_x), .i_draw_y(draw_y), .i_sync(scan_sync),
    .i_player_x(player_x), .i_player_y(player_y), .i_tile_state(disp_state),
    .o_map_addr(disp_addr), .o_rgb, .o_sync(pix_sync)
  );

  assign o_hsync = pix_sync.hsync;
  assign o_vsync = pix_sync.vsync;
  assign o_de    = pix_sync.de;

endmodule

// File: game_pkg.sv
package game_pkg;

  // tile state storage
  localparam int MAP_MEM_WIDTH = 2; // bits per tile

  typedef enum logic [MAP_MEM_WIDTH-1:0] {
    no_blk          = 2'd0, // empty floor
    perm_blk        = 2'd1, // solid wall
    destroyable_blk = 2'd2, // breakable crate
    bomb            = 2'd3
  } tile_state_e;

  // bus geometry and address map
  localparam int AXIL_ADDR_W = 12;
  localparam int AXIL_DATA_W = 32;
  localparam logic [AXIL_ADDR_W-1:0] PLAYER_ADDR = 12'h800; // tiles sit below, 4 bytes each

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // request payloads
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0]   data;
    logic [AXIL_DATA_W/8-1:0] strb; // accepted, full-word writes only
  } axil_w_t;

  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] addr;
  } axil_ar_t;

  // response payloads
  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
  } axil_r_t;

  // one bus word, seen as a tile state or as a player position
  typedef union packed {
    struct packed {
      logic [29:0] rsvd;
      tile_state_e state;
    } tile_word;
    struct packed {
      logic [4:0]  rsvd_hi;
      logic [10:0] x;       // bits 26:16
      logic [5:0]  rsvd_lo;
      logic [9:0]  y;       // bits 9:0
    } player_word;
  } axil_wdata_u;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  localparam rgb_t COL_BORDER = rgb_t'(12'hFFF);
  localparam rgb_t COL_BG     = rgb_t'(12'h000);
  localparam rgb_t COL_PERM   = rgb_t'(12'hFFF);
  localparam rgb_t COL_DESTR  = rgb_t'(12'h00F);
  localparam rgb_t COL_BOMB   = rgb_t'(12'h333);
  localparam rgb_t COL_PLAYER = rgb_t'(12'hF80);

  typedef struct packed {
    logic hsync; // active low
    logic vsync; // active low
    logic de;
  } sync_t;

endpackage

// File: map_axil_regs.sv
`timescale 1ns/1ps

module map_axil_regs #(
  parameter int NUM_COL = 19,
  parameter int NUM_ROW = 11,
  localparam int ADDR_WIDTH = $clog2(NUM_COL * NUM_ROW)
) (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  // write address
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  game_pkg::axil_aw_t      i_aw,
  // write data
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  game_pkg::axil_w_t       i_w,
  // write response
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output game_pkg::axil_b_t       o_b,
  // read address
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  game_pkg::axil_ar_t      i_ar,
  // read data
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output game_pkg::axil_r_t       o_r,
  // tile memory, port A
  output logic                    o_mem_we,
  output logic                    o_mem_re,
  output logic [ADDR_WIDTH-1:0]   o_mem_addr,
  output game_pkg::tile_state_e   o_mem_wstate,
  input  game_pkg::tile_state_e   i_mem_rstate,
  // player top-left corner
  output logic [10:0]             o_player_x,
  output logic [9:0]              o_player_y
);

  // tile n at byte address 4*n
  localparam logic [game_pkg::AXIL_ADDR_W-1:0] TILE_SPAN =
    game_pkg::AXIL_ADDR_W'(4 * NUM_COL * NUM_ROW);

  game_pkg::axil_wdata_u wr_word; // incoming word, two views
  game_pkg::axil_wdata_u rd_word; // outgoing word, built the same way
  logic wr_accept, rd_accept;
  logic wr_is_tile, wr_is_player;
  logic rd_is_tile, rd_is_player;
  logic rd_s1;                    // memory read in flight
  logic rd_tile_q, rd_player_q;   // decode carried alongside it

  assign wr_word = i_w.data;

  // AW and W together, only with no B outstanding
  assign wr_accept = i_awvalid && i_wvalid && !o_bvalid;
  assign o_awready = wr_accept;
  assign o_wready  = wr_accept;

  // a write owns port A that cycle, so reads wait one
  assign rd_accept = i_arvalid && !rd_s1 && !o_rvalid && !wr_accept;
  assign o_arready = rd_accept;

  assign wr_is_tile   = (i_aw.addr < TILE_SPAN);
  assign wr_is_player = (i_aw.addr == game_pkg::PLAYER_ADDR);
  assign rd_is_tile   = (i_ar.addr < TILE_SPAN);
  assign rd_is_player = (i_ar.addr == game_pkg::PLAYER_ADDR);

  // port A: drop the byte offset to get the tile index
  assign o_mem_we     = wr_accept && wr_is_tile;
  assign o_mem_re     = rd_accept && rd_is_tile;
  assign o_mem_addr   = wr_accept ? i_aw.addr[ADDR_WIDTH+1:2] : i_ar.addr[ADDR_WIDTH+1:2];
  assign o_mem_wstate = wr_word.tile_word.state;

  // write response and player register
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_bvalid   <= 1'b0;
      o_player_x <= '0; // corner pixel, border covers it
      o_player_y <= '0;
    end else begin
      if (wr_accept) begin
        o_bvalid <= 1'b1;
        if (wr_is_player) begin
          o_player_x <= wr_word.player_word.x;
          o_player_y <= wr_word.player_word.y;
        end
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_accept)
      o_b.resp <= (wr_is_tile || wr_is_player) ? game_pkg::RESP_OKAY : game_pkg::RESP_SLVERR;
  end

  // read: accept, memory cycle, then R
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_s1    <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      rd_s1 <= rd_accept;
      if (rd_s1)
        o_rvalid <= 1'b1;
      else if (i_rready)
        o_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_accept) begin
      rd_tile_q   <= rd_is_tile;
      rd_player_q <= rd_is_player;
    end
  end

  // reserved bits and bad addresses read as zero
  always_comb begin
    rd_word = '0;
    if (rd_tile_q) begin
      rd_word.tile_word.state = i_mem_rstate;
    end else if (rd_player_q) begin
      rd_word.player_word.x = o_player_x;
      rd_word.player_word.y = o_player_y;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_s1) begin
      o_r.data <= rd_word;
      o_r.resp <= (rd_tile_q || rd_player_q) ? game_pkg::RESP_OKAY : game_pkg::RESP_SLVERR;
    end
  end

endmodule

// File: map_memory.sv
`timescale 1ns/1ps

module map_memory #(
  parameter int NUM_COL = 19,
  parameter int NUM_ROW = 11,
  localparam int DEPTH      = NUM_COL * NUM_ROW,
  localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  // host port
  input  logic                    i_a_we,
  input  logic                    i_a_re,
  input  logic [ADDR_WIDTH-1:0]   i_a_addr,
  input  game_pkg::tile_state_e   i_a_wstate,
  output game_pkg::tile_state_e   o_a_rstate,
  // display port, read only
  input  logic [ADDR_WIDTH-1:0]   i_b_addr,
  output game_pkg::tile_state_e   o_b_state
);

  game_pkg::tile_state_e mem [DEPTH];

  // whole map starts empty
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= game_pkg::no_blk;
      o_a_rstate <= game_pkg::no_blk;
      o_b_state  <= game_pkg::no_blk;
    end else begin
      if (i_a_we)
        mem[i_a_addr] <= i_a_wstate;
      if (i_a_re)
        o_a_rstate <= mem[i_a_addr]; // held until next read
      o_b_state <= mem[i_b_addr];    // old value on a colliding write
    end
  end

endmodule

// File: raster_timing.sv
`timescale 1ns/1ps

module raster_timing #(
  parameter int SCREEN_W = 1280,
  parameter int SCREEN_H = 800,
  parameter int H_FP     = 48,
  parameter int H_SYNC   = 32,
  parameter int H_BP     = 80,
  parameter int V_FP     = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BP     = 14
) (
  input  logic              i_clk,
  input  logic              i_arst_n,
  output logic [10:0]       o_draw_x,
  output logic [9:0]        o_draw_y,
  output game_pkg::sync_t   o_sync
);

  // line and frame lengths, visible area first
  localparam int H_TOTAL   = SCREEN_W + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL   = SCREEN_H + V_FP + V_SYNC + V_BP;
  localparam int HS_START  = SCREEN_W + H_FP;
  localparam int HS_END    = HS_START + H_SYNC;
  localparam int VS_START  = SCREEN_H + V_FP;
  localparam int VS_END    = VS_START + V_SYNC;

  logic [10:0] x_q;
  logic [9:0]  y_q;
  logic        x_last;
  logic        y_last;

  assign x_last = (x_q == 11'(H_TOTAL - 1));
  assign y_last = (y_q == 10'(V_TOTAL - 1));

  // free-running scan, never stalled
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      x_q <= '0;
      y_q <= '0;
    end else if (x_last) begin
      x_q <= '0;
      y_q <= y_last ? '0 : y_q + 10'd1; // wrap at end of frame
    end else begin
      x_q <= x_q + 11'd1;
    end
  end

  assign o_draw_x = x_q;
  assign o_draw_y = y_q;

  // unregistered view, drawcon lines it up with the pixel
  always_comb begin
    o_sync.hsync = !((x_q >= 11'(HS_START)) && (x_q < 11'(HS_END)));
    o_sync.vsync = !((y_q >= 10'(VS_START)) && (y_q < 10'(VS_END)));
    o_sync.de    = (x_q < 11'(SCREEN_W)) && (y_q < 10'(SCREEN_H)); // visible area only
  end

endmodule

// File: sim.f
game_pkg.sv
raster_timing.sv
map_memory.sv
map_axil_regs.sv
drawcon.sv
game_display_top.sv
tb_clock_gen.sv
game_display_properties.sv
tb_game_display.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  // free-running, first rising edge at half a period
  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: tb_game_display.sv
`timescale 1ns/1ps

module tb_game_display;

  localparam int SCREEN_W  = 128;
  localparam int SCREEN_H  = 96;
  localparam int BRD_H     = 16;
  localparam int BRD_TOP   = 16;
  localparam int BRD_BOT   = 16;
  localparam int BLK_W     = 16;
  localparam int BLK_H     = 16;
  localparam int NUM_COL   = 6;
  localparam int NUM_ROW   = 4;
  localparam int NUM_TILES = NUM_COL * NUM_ROW;
  localparam int H_FP      = 4;
  localparam int H_SYNC    = 8;
  localparam int H_BP      = 4;
  localparam int V_FP      = 2;
  localparam int V_SYNC    = 2;
  localparam int V_BP      = 2;
  localparam int PLAYER_X  = 104; // reaches into the right border
  localparam int PLAYER_Y  = 72;  // and into the bottom one
  localparam int BUS_WAIT  = 20;  // cycles for one response
  // frame is 144 x 102 = 14688 cycles, five frames plus bus traffic
  localparam int TIMEOUT_CYCLES = 100000;

  logic               clk;
  logic               arst_n;
  logic               awvalid, wvalid, bready, arvalid, rready;
  game_pkg::axil_aw_t aw;
  game_pkg::axil_w_t  w;
  game_pkg::axil_ar_t ar;
  logic               o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
  game_pkg::axil_b_t  o_b;
  game_pkg::axil_r_t  o_r;
  game_pkg::rgb_t     o_rgb;
  logic               o_hsync, o_vsync, o_de;

  int         errors = 0;
  int         cycles = 0;
  logic [1:0] tile_model [NUM_TILES]; // expected map contents
  int         player_x = 0;
  int         player_y = 0;

  tb_clock_gen #(.PERIOD_NS(20)) clock_gen_i (.o_clk(clk));

  game_display_top #(
    .SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H),
    .BRD_H(BRD_H), .BRD_TOP(BRD_TOP), .BRD_BOT(BRD_BOT),
    .BLK_W(BLK_W), .BLK_H(BLK_H), .NUM_COL(NUM_COL), .NUM_ROW(NUM_ROW),
    .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) game_display_top_i (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_awvalid(awvalid), .o_awready, .i_aw(aw),
    .i_wvalid(wvalid), .o_wready, .i_w(w),
    .o_bvalid, .i_bready(bready), .o_b,
    .i_arvalid(arvalid), .o_arready, .i_ar(ar),
    .o_rvalid, .i_rready(rready), .o_r,
    .o_rgb, .o_hsync, .o_vsync, .o_de
  );

  // colour by priority: border, player, tile
  function automatic logic [11:0] expected_rgb(input int px, input int py);
    int col, row;
    if (px < BRD_H || px >= SCREEN_W - BRD_H || py < BRD_TOP || py >= SCREEN_H - BRD_BOT)
      return 12'hFFF;
    if (px >= player_x && px < player_x + BLK_W && py >= player_y && py < player_y + BLK_H)
      return 12'hF80;
    col = (px - BRD_H) / BLK_W;
    row = (py - BRD_TOP) / BLK_H;
    case (tile_model[row * NUM_COL + col])
      2'd1:    return 12'hFFF; // wall
      2'd2:    return 12'h00F; // crate
      2'd3:    return 12'h333; // bomb
      default: return 12'h000;
    endcase
  endfunction

  // AW and W together, wait for B
  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    int waited;
    waited = 0;
    @(negedge clk);
    awvalid = 1'b1;
    aw.addr = addr;
    wvalid  = 1'b1;
    w.data  = data;
    w.strb  = 4'hF;
    bready  = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!o_bvalid && waited < BUS_WAIT);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!o_bvalid) begin
      $display("ERROR at %0t: no write response for address %h", $time, addr);
      errors++;
    end else if (o_b.resp !== exp_resp) begin
      $display("MISMATCH at %0t: o_b.resp got %h expected %h (addr %h)",
               $time, o_b.resp, exp_resp, addr);
      errors++;
    end
  endtask

  task automatic axil_read(input logic [11:0] addr, input logic [1:0] exp_resp,
                           output logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge clk);
    arvalid = 1'b1;
    ar.addr = addr;
    rready  = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!o_rvalid && waited < BUS_WAIT);
    // AR still offered, R held, so no second accept
    if (o_rvalid && o_arready !== 1'b0) begin
      $display("MISMATCH at %0t: o_arready got %b expected 0", $time, o_arready);
      errors++;
    end
    arvalid = 1'b0;
    data    = o_r.data;
    if (!o_rvalid) begin
      $display("ERROR at %0t: no read response for address %h", $time, addr);
      errors++;
    end else if (o_r.resp !== exp_resp) begin
      $display("MISMATCH at %0t: o_r.resp got %h expected %h (addr %h)",
               $time, o_r.resp, exp_resp, addr);
      errors++;
    end
  endtask

  task automatic verify_tiles();
    logic [31:0] rdata;
    for (int i = 0; i < NUM_TILES; i++) begin
      axil_read(12'(4 * i), game_pkg::RESP_OKAY, rdata);
      if (rdata !== {30'd0, tile_model[i]}) begin
        $display("MISMATCH at %0t: o_r.data tile %0d got %h expected %h",
                 $time, i, rdata, {30'd0, tile_model[i]});
        errors++;
      end
    end
  endtask

  // next full frame after vsync, pixel position from the de count
  task automatic frame_check(input string tag);
    int n, bad, hs_low;
    logic [11:0] exp_rgb;
    n      = 0;
    bad    = 0;
    hs_low = 0;
    @(negedge clk);
    while (o_vsync) @(negedge clk);
    while (!o_vsync) @(negedge clk);
    while (n < SCREEN_W * SCREEN_H) begin
      @(negedge clk);
      if (!o_hsync)
        hs_low++;
      if (o_de) begin
        exp_rgb = expected_rgb(n % SCREEN_W, n / SCREEN_W);
        if (o_rgb !== exp_rgb) begin
          if (bad < 10)
            $display("MISMATCH at %0t: o_rgb %s frame (%0d,%0d) got %h expected %h",
                     $time, tag, n % SCREEN_W, n / SCREEN_W, o_rgb, exp_rgb);
          bad++;
          errors++;
        end
        n++;
      end
    end
    if (bad > 10)
      $display("ERROR: %0d more wrong pixels in the %s frame", bad - 10, tag);
    // back porch lines and every visible line but the last carry a full pulse
    if (hs_low != (V_BP + SCREEN_H - 1) * H_SYNC) begin
      $display("MISMATCH at %0t: o_hsync low cycles in %s frame got %0d expected %0d",
               $time, tag, hs_low, (V_BP + SCREEN_H - 1) * H_SYNC);
      errors++;
    end
  endtask

  task automatic reset_state_check();
    if (o_bvalid !== 1'b0) begin
      $display("MISMATCH at %0t: o_bvalid got %b expected 0", $time, o_bvalid);
      errors++;
    end
    if (o_rvalid !== 1'b0) begin
      $display("MISMATCH at %0t: o_rvalid got %b expected 0", $time, o_rvalid);
      errors++;
    end
    if (o_de !== 1'b0) begin
      $display("MISMATCH at %0t: o_de got %b expected 0", $time, o_de);
      errors++;
    end
    if (o_hsync !== 1'b1) begin
      $display("MISMATCH at %0t: o_hsync got %b expected 1", $time, o_hsync);
      errors++;
    end
    if (o_vsync !== 1'b1) begin
      $display("MISMATCH at %0t: o_vsync got %b expected 1", $time, o_vsync);
      errors++;
    end
    if (o_rgb !== 12'h000) begin
      $display("MISMATCH at %0t: o_rgb got %h expected 000", $time, o_rgb);
      errors++;
    end
  endtask

  task automatic round_trip_tiles();
    logic [1:0] st;
    for (int i = 0; i < NUM_TILES; i++) begin
      st = (i < 4) ? 2'(i) : 2'($urandom % 4); // first four cover every state
      tile_model[i] = st;
      axil_write(12'(4 * i), {30'd0, st}, game_pkg::RESP_OKAY);
    end
    verify_tiles();
  endtask

  task automatic player_overlay();
    logic [31:0] rdata;
    logic [31:0] pword;
    pword = {5'd0, 11'(PLAYER_X), 6'd0, 10'(PLAYER_Y)};
    axil_write(game_pkg::PLAYER_ADDR, pword, game_pkg::RESP_OKAY);
    player_x = PLAYER_X;
    player_y = PLAYER_Y;
    axil_read(game_pkg::PLAYER_ADDR, game_pkg::RESP_OKAY, rdata);
    if (rdata !== pword) begin
      $display("MISMATCH at %0t: o_r.data player got %h expected %h", $time, rdata, pword);
      errors++;
    end
    frame_check("player");
  endtask

  task automatic bad_address_access();
    logic [31:0] rdata;
    logic [31:0] pword;
    axil_write(12'(4 * NUM_TILES), 32'h3, game_pkg::RESP_SLVERR); // one past the map
    axil_write(12'h804, 32'h0010_0010, game_pkg::RESP_SLVERR);     // next to player reg
    axil_read(12'(4 * NUM_TILES), game_pkg::RESP_SLVERR, rdata);
    if (rdata !== 32'd0) begin
      $display("MISMATCH at %0t: o_r.data bad address got %h expected 0", $time, rdata);
      errors++;
    end
    pword = {5'd0, 11'(player_x), 6'd0, 10'(player_y)};
    axil_read(game_pkg::PLAYER_ADDR, game_pkg::RESP_OKAY, rdata);
    if (rdata !== pword) begin
      $display("MISMATCH at %0t: o_r.data player after bad write got %h expected %h",
               $time, rdata, pword);
      errors++;
    end
    verify_tiles(); // map untouched
  endtask

  // hold B for 10 cycles with a second write waiting
  task automatic bresp_backpressure();
    int waited;
    logic [1:0] st5, st6;
    waited = 0;
    st5    = tile_model[5] + 2'd1; // new states always differ from the stored ones
    st6    = tile_model[6] + 2'd2;
    @(negedge clk);
    bready  = 1'b0;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    aw.addr = 12'(4 * 5);
    w.data  = {30'd0, st5};
    do begin
      @(negedge clk);
      waited++;
    end while (!o_bvalid && waited < BUS_WAIT);
    tile_model[5] = st5;
    aw.addr = 12'(4 * 6); // second write
    w.data  = {30'd0, st6};
    repeat (10) begin
      @(negedge clk);
      if (o_bvalid !== 1'b1) begin
        $display("MISMATCH at %0t: o_bvalid got %b expected 1", $time, o_bvalid);
        errors++;
      end
      if (o_awready !== 1'b0) begin
        $display("MISMATCH at %0t: o_awready got %b expected 0", $time, o_awready);
        errors++;
      end
      if (o_wready !== 1'b0) begin
        $display("MISMATCH at %0t: o_wready got %b expected 0", $time, o_wready);
        errors++;
      end
    end
    bready = 1'b1;
    @(negedge clk); // B taken here, queued write now offered
    if (o_awready !== 1'b1) begin
      $display("MISMATCH at %0t: o_awready got %b expected 1", $time, o_awready);
      errors++;
    end
    if (o_wready !== 1'b1) begin
      $display("MISMATCH at %0t: o_wready got %b expected 1", $time, o_wready);
      errors++;
    end
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!o_bvalid && waited < BUS_WAIT);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!o_bvalid) begin
      $display("ERROR at %0t: queued write never completed", $time);
      errors++;
    end else if (o_b.resp !== game_pkg::RESP_OKAY) begin
      $display("MISMATCH at %0t: o_b.resp got %h expected %h",
               $time, o_b.resp, game_pkg::RESP_OKAY);
      errors++;
    end
    tile_model[6] = st6;
    verify_tiles();
  endtask

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: timeout after %0d cycles, tests did not finish", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(27));
    arst_n  = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    aw      = '0;
    w       = '0;
    ar      = '0;
    foreach (tile_model[i]) tile_model[i] = 2'd0; // map clears on reset
    repeat (8) @(negedge clk);
    reset_state_check();
    arst_n = 1'b1;
    frame_check("reset");
    round_trip_tiles();
    frame_check("tiles");
    player_overlay();
    bad_address_access();
    bresp_backpressure();
    errors += game_display_top_i.game_display_properties_i.assert_fails;
    $display("summary: %0d errors, %0d assertion failures, %0d cycles", errors,
             game_display_top_i.game_display_properties_i.assert_fails, cycles);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
